// File: src/issue_pkg.sv
package issue_pkg;

	// Core sizes
	localparam int XLEN           = 32;
	localparam int PREG_COUNT     = 64;
	localparam int RS_DEPTH       = 16;
	localparam int ALU_COUNT      = 2;
	localparam int DISPATCH_WIDTH = 2;

	// RISC-V major opcodes handled by the ALUs
	localparam logic [6:0] OP_IMM = 7'b0010011; // ADDI, ANDI
	localparam logic [6:0] OP_REG = 7'b0110011; // ADD, SUB, XOR, SRA

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRA = 3'b101;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRA variant

	typedef logic [$clog2(PREG_COUNT)-1:0] preg_t;
	typedef logic [3:0] tag_t;
	typedef logic alu_sel_t;

	// One renamed instruction from the front end
	typedef struct packed {
		logic            valid;
		logic [6:0]      opcode;
		logic [2:0]      func3;
		logic [6:0]      func7;
		logic [31:0]     instr;
		preg_t           ps1;
		preg_t           ps2;
		preg_t           pd;
		tag_t            tag;
	} dispatch_t;

	typedef struct packed {
		logic            in_use;
		logic [6:0]      opcode;
		logic [2:0]      func3;
		logic [6:0]      func7;
		logic            is_imm;
		logic [XLEN-1:0] imm;    // Already sign-extended
		preg_t           src1;
		preg_t           src2;
		logic [XLEN-1:0] data1;
		logic [XLEN-1:0] data2;
		logic            rdy1;
		logic            rdy2;
		preg_t           pd;
		tag_t            tag;
		alu_sel_t        alu_sel;
	} rs_entry_t;

	typedef struct packed {
		logic            valid;
		logic [6:0]      opcode;
		logic [2:0]      func3;
		logic [6:0]      func7;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
		preg_t           pd;
		tag_t            tag;
	} issue_t;

	typedef struct packed {
		logic            valid;
		preg_t           pd;
		tag_t            tag;
		logic [XLEN-1:0] value;
	} result_t;

endpackage

// File: src/dispatch_decode.sv
`timescale 1ns/1ps

module dispatch_decode import issue_pkg::*; (
	input  logic      clock,
	input  logic      rst_i,
	input  dispatch_t slot_i [DISPATCH_WIDTH],
	input  logic      accept_i,
	output rs_entry_t entry_o [DISPATCH_WIDTH]
);

	logic                      alu_toggle; // ALU for the next supported instruction
	logic [DISPATCH_WIDTH-1:0] supported;
	alu_sel_t                  next_sel [DISPATCH_WIDTH+1];

	// Only the six ALU operations are kept, everything else is discarded
	function automatic logic is_supported(input dispatch_t s);
		logic ok;
		ok = 1'b0;
		case (s.opcode)
			OP_IMM: ok = (s.func3 == F3_ADD) || (s.func3 == F3_AND);
			OP_REG: begin
				case (s.func3)
					F3_ADD:  ok = (s.func7 == 7'd0) || (s.func7 == F7_ALT);
					F3_XOR:  ok = (s.func7 == 7'd0);
					F3_SRA:  ok = (s.func7 == F7_ALT);
					default: ok = 1'b0;
				endcase
			end
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

	always_comb begin
		next_sel[0] = alu_toggle;
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			supported[k] = slot_i[k].valid && is_supported(slot_i[k]);

			entry_o[k]         = '0; // Operands are filled by the register file
			entry_o[k].in_use  = supported[k];
			entry_o[k].opcode  = slot_i[k].opcode;
			entry_o[k].func3   = slot_i[k].func3;
			entry_o[k].func7   = slot_i[k].func7;
			entry_o[k].is_imm  = (slot_i[k].opcode == OP_IMM);
			entry_o[k].imm     = {{(XLEN-12){slot_i[k].instr[31]}}, slot_i[k].instr[31:20]};
			entry_o[k].src1    = slot_i[k].ps1;
			entry_o[k].src2    = entry_o[k].is_imm ? '0 : slot_i[k].ps2;
			entry_o[k].pd      = slot_i[k].pd;
			entry_o[k].tag     = slot_i[k].tag;
			entry_o[k].alu_sel = next_sel[k];

			// Skip the toggle for discarded slots
			next_sel[k+1] = next_sel[k] ^ supported[k];
		end
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			alu_toggle <= 1'b0;
		end else if (accept_i) begin
			alu_toggle <= next_sel[DISPATCH_WIDTH];
		end
	end

endmodule

// File: src/preg_file.sv
`timescale 1ns/1ps

module preg_file import issue_pkg::*; #(
	parameter int PREG_COUNT = issue_pkg::PREG_COUNT
) (
	input  logic      clock,
	input  logic      rst_i,
	input  rs_entry_t read_entry_i [DISPATCH_WIDTH],
	input  logic      accept_i,
	input  result_t   result_i [ALU_COUNT],
	output rs_entry_t filled_entry_o [DISPATCH_WIDTH]
);

	logic [XLEN-1:0]       value_q [PREG_COUNT];
	logic [PREG_COUNT-1:0] ready_q; // Scoreboard, 1 means value is valid

	// Register read with bypass from results written on this edge
	function automatic void read_src(
		input  preg_t           r,
		output logic [XLEN-1:0] d,
		output logic            rdy
	);
		d   = value_q[r];
		rdy = ready_q[r];
		for (int j = 0; j < ALU_COUNT; j++) begin
			if (result_i[j].valid && result_i[j].pd == r) begin
				d   = result_i[j].value;
				rdy = 1'b1;
			end
		end
		if (r == '0) begin
			d   = '0; // p0 is hardwired
			rdy = 1'b1;
		end
	endfunction

	always_comb begin
		logic [XLEN-1:0] d;
		logic            rdy;
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			filled_entry_o[k] = read_entry_i[k];

			read_src(read_entry_i[k].src1, d, rdy);
			filled_entry_o[k].data1 = d;
			filled_entry_o[k].rdy1  = rdy;

			read_src(read_entry_i[k].src2, d, rdy);
			filled_entry_o[k].data2 = read_entry_i[k].is_imm ? read_entry_i[k].imm : d;
			filled_entry_o[k].rdy2  = read_entry_i[k].is_imm || rdy;

			// Older slot in the same group produces this source
			for (int m = 0; m < k; m++) begin
				if (read_entry_i[m].in_use && read_entry_i[m].pd != '0) begin
					if (read_entry_i[m].pd == read_entry_i[k].src1) begin
						filled_entry_o[k].rdy1 = 1'b0;
					end
					if (!read_entry_i[k].is_imm && read_entry_i[m].pd == read_entry_i[k].src2) begin
						filled_entry_o[k].rdy2 = 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			for (int i = 0; i < PREG_COUNT; i++) begin
				value_q[i] <= '0;
			end
			ready_q <= '1;
		end else begin
			for (int j = 0; j < ALU_COUNT; j++) begin
				if (result_i[j].valid && result_i[j].pd != '0) begin
					value_q[result_i[j].pd] <= result_i[j].value;
					ready_q[result_i[j].pd] <= 1'b1;
				end
			end
			// New producers go busy; this wins over a writeback on the same edge
			if (accept_i) begin
				for (int k = 0; k < DISPATCH_WIDTH; k++) begin
					if (read_entry_i[k].in_use && read_entry_i[k].pd != '0) begin
						ready_q[read_entry_i[k].pd] <= 1'b0;
					end
				end
			end
		end
	end

endmodule

// File: src/reservation_station.sv
`timescale 1ns/1ps

module reservation_station import issue_pkg::*; #(
	parameter int RS_DEPTH = issue_pkg::RS_DEPTH
) (
	input  logic                      clock,
	input  logic                      rst_i,
	input  rs_entry_t                 entry_i [DISPATCH_WIDTH],
	input  logic [DISPATCH_WIDTH-1:0] dispatch_valid_i,
	output logic                      ready_o,
	input  result_t                   result_i [ALU_COUNT],
	output issue_t                    issue_o [ALU_COUNT]
);

	localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
	localparam int CNT_W = $clog2(RS_DEPTH + 1);

	rs_entry_t            rows_q [RS_DEPTH];
	rs_entry_t            woken  [RS_DEPTH]; // Rows with this cycle's results captured
	rs_entry_t            rows_d [RS_DEPTH];
	logic [IDX_W-1:0]     free_idx [DISPATCH_WIDTH];
	logic [CNT_W-1:0]     free_cnt;
	logic [IDX_W-1:0]     pick_idx [ALU_COUNT];
	logic [ALU_COUNT-1:0] pick_found;

	// Free rows, counted before any issue of this cycle
	always_comb begin
		free_cnt = '0;
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			free_idx[k] = '0;
		end
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!rows_q[i].in_use) begin
				free_cnt = free_cnt + CNT_W'(1);
				// Shift so free_idx[0] ends on the lowest free row
				for (int k = DISPATCH_WIDTH - 1; k > 0; k--) begin
					free_idx[k] = free_idx[k-1];
				end
				free_idx[0] = IDX_W'(i);
			end
		end
	end

	assign ready_o = (free_cnt >= CNT_W'(DISPATCH_WIDTH));

	// Wakeup with operand capture
	always_comb begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			woken[i] = rows_q[i];
			for (int j = 0; j < ALU_COUNT; j++) begin
				if (result_i[j].valid && result_i[j].pd != '0) begin
					if (!woken[i].rdy1 && woken[i].src1 == result_i[j].pd) begin
						woken[i].data1 = result_i[j].value;
						woken[i].rdy1  = 1'b1;
					end
					if (!woken[i].rdy2 && woken[i].src2 == result_i[j].pd) begin
						woken[i].data2 = result_i[j].value;
						woken[i].rdy2  = 1'b1;
					end
				end
			end
		end
	end

	// Per-ALU select, lowest index wins
	always_comb begin
		for (int a = 0; a < ALU_COUNT; a++) begin
			pick_found[a] = 1'b0;
			pick_idx[a]   = '0;
			for (int i = RS_DEPTH - 1; i >= 0; i--) begin
				if (woken[i].in_use && woken[i].alu_sel == alu_sel_t'(a) &&
						woken[i].rdy1 && woken[i].rdy2) begin
					pick_found[a] = 1'b1;
					pick_idx[a]   = IDX_W'(i);
				end
			end

			issue_o[a].valid  = pick_found[a];
			issue_o[a].opcode = woken[pick_idx[a]].opcode;
			issue_o[a].func3  = woken[pick_idx[a]].func3;
			issue_o[a].func7  = woken[pick_idx[a]].func7;
			issue_o[a].op_a   = woken[pick_idx[a]].data1;
			issue_o[a].op_b   = woken[pick_idx[a]].data2;
			issue_o[a].pd     = woken[pick_idx[a]].pd;
			issue_o[a].tag    = woken[pick_idx[a]].tag;
		end
	end

	always_comb begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			rows_d[i] = woken[i];
		end
		for (int a = 0; a < ALU_COUNT; a++) begin
			if (pick_found[a]) begin
				rows_d[pick_idx[a]].in_use = 1'b0; // Issued rows free up
			end
		end
		// Allocation only touches rows that were free, so no clash with issue
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			if (dispatch_valid_i[k]) begin
				rows_d[free_idx[k]] = entry_i[k];
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (rst_i) begin
				rows_q[i].in_use <= 1'b0;
			end else begin
				rows_q[i] <= rows_d[i];
			end
		end
	end

endmodule

// File: src/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import issue_pkg::*; (
	input  logic    clock,
	input  logic    rst_i,
	input  issue_t  issue_i,
	output result_t result_o
);

	logic [XLEN-1:0] value;

	always_comb begin
		value = '0;
		case (issue_i.opcode)
			OP_REG: begin
				case (issue_i.func3)
					F3_ADD: begin
						if (issue_i.func7 == F7_ALT) begin
							value = issue_i.op_a - issue_i.op_b; // SUB
						end else begin
							value = issue_i.op_a + issue_i.op_b;
						end
					end
					F3_XOR:  value = issue_i.op_a ^ issue_i.op_b;
					F3_SRA:  value = $signed(issue_i.op_a) >>> issue_i.op_b[4:0];
					default: value = '0;
				endcase
			end
			OP_IMM: begin
				case (issue_i.func3)
					F3_ADD:  value = issue_i.op_a + issue_i.op_b; // ADDI
					F3_AND:  value = issue_i.op_a & issue_i.op_b; // ANDI
					default: value = '0;
				endcase
			end
			default: value = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			result_o.valid <= 1'b0;
		end else begin
			result_o.valid <= issue_i.valid;
		end
		result_o.pd    <= issue_i.pd;
		result_o.tag   <= issue_i.tag;
		result_o.value <= value;
	end

endmodule

// File: src/issue_core.sv
`timescale 1ns/1ps

module issue_core import issue_pkg::*; #(
	parameter int RS_DEPTH   = issue_pkg::RS_DEPTH,
	parameter int PREG_COUNT = issue_pkg::PREG_COUNT
) (
	input  logic      clock,
	input  logic      rst_i,
	input  dispatch_t slot_i [DISPATCH_WIDTH],
	output logic      dispatch_ready_o,
	output result_t   result_o [ALU_COUNT]
);

	rs_entry_t                 decoded [DISPATCH_WIDTH];
	rs_entry_t                 filled  [DISPATCH_WIDTH];
	logic [DISPATCH_WIDTH-1:0] rs_write;
	issue_t                    issue   [ALU_COUNT];

	always_comb begin
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			rs_write[k] = filled[k].in_use && dispatch_ready_o;
		end
	end

	dispatch_decode i_decode (
		.clock    (clock),
		.rst_i    (rst_i),
		.slot_i   (slot_i),
		.accept_i (dispatch_ready_o),
		.entry_o  (decoded)
	);

	preg_file #(
		.PREG_COUNT (PREG_COUNT)
	) i_preg (
		.clock          (clock),
		.rst_i          (rst_i),
		.read_entry_i   (decoded),
		.accept_i       (dispatch_ready_o),
		.result_i       (result_o),
		.filled_entry_o (filled)
	);

	reservation_station #(
		.RS_DEPTH (RS_DEPTH)
	) i_rs (
		.clock            (clock),
		.rst_i            (rst_i),
		.entry_i          (filled),
		.dispatch_valid_i (rs_write),
		.ready_o          (dispatch_ready_o),
		.result_i         (result_o),
		.issue_o          (issue)
	);

	for (genvar a = 0; a < ALU_COUNT; a++) begin : g_alu
		alu_unit i_alu (
			.clock    (clock),
			.rst_i    (rst_i),
			.issue_i  (issue[a]),
			.result_o (result_o[a])
		);
	end

endmodule

// File: tb/issue_core_tests.svh
// Queues one instruction with the next tag
task automatic push_instr(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7,
		input logic [11:0] imm, input preg_t ps1, input preg_t ps2, input preg_t pd);
	dispatch_t d;
	d        = '0;
	d.valid  = 1'b1;
	d.opcode = op;
	d.func3  = f3;
	d.func7  = f7;
	d.ps1    = ps1;
	d.ps2    = (op == 7'b0010011) ? preg_t'(0) : ps2;
	d.pd     = pd;
	d.tag    = next_tag;
	d.instr  = (op == 7'b0010011) ? {imm, ps1[4:0], f3, pd[4:0], op}
		: {f7, ps2[4:0], ps1[4:0], f3, pd[4:0], op};
	next_tag = next_tag + 4'd1;
	stim_q.push_back(d);
endtask

task automatic build_imm_test();
	push_instr(7'b0010011, 3'b000, 7'h00, 12'd77, 6'd0, 6'd0, 6'd0);  // Into p0
	push_instr(7'b0010011, 3'b000, 7'h00, 12'hffb, 6'd0, 6'd0, 6'd1); // -5
	push_instr(7'b0010011, 3'b111, 7'h00, 12'hfff, 6'd0, 6'd0, 6'd2);
	push_instr(7'b0010011, 3'b000, 7'h00, 12'h7ff, 6'd0, 6'd0, 6'd3);
	push_instr(7'b0010011, 3'b000, 7'h00, 12'h800, 6'd0, 6'd0, 6'd4); // -2048
	push_instr(7'b0010011, 3'b000, 7'h00, 12'd1, 6'd0, 6'd0, 6'd5);   // Reads p0 during its write
	push_instr(7'b0010011, 3'b111, 7'h00, 12'hff0, 6'd3, 6'd0, 6'd6);
	push_instr(7'b0010011, 3'b111, 7'h00, 12'hfff, 6'd1, 6'd0, 6'd7);
endtask

task automatic build_chain_test();
	push_instr(7'b0110011, 3'b000, 7'h00, 12'd0, 6'd1, 6'd3, 6'd10);
	push_instr(7'b0110011, 3'b000, 7'h20, 12'd0, 6'd10, 6'd4, 6'd11); // Reads slot 0
	push_instr(7'b0110011, 3'b100, 7'h00, 12'd0, 6'd11, 6'd1, 6'd12);
	push_instr(7'b0110011, 3'b101, 7'h20, 12'd0, 6'd12, 6'd6, 6'd13);
	push_instr(7'b0110011, 3'b101, 7'h20, 12'd0, 6'd4, 6'd5, 6'd14);
	push_instr(7'b0110011, 3'b000, 7'h20, 12'd0, 6'd13, 6'd14, 6'd15);
	push_instr(7'b0110011, 3'b100, 7'h00, 12'd0, 6'd15, 6'd15, 6'd16);
	push_instr(7'b0110011, 3'b000, 7'h00, 12'd0, 6'd16, 6'd15, 6'd17);
endtask

// Serial chain issues one per cycle while two dispatch per cycle
task automatic build_backpressure_test();
	push_instr(7'b0010011, 3'b000, 7'h00, 12'd3, 6'd0, 6'd0, 6'd20);
	for (int i = 0; i < 39; i++) begin
		push_instr(7'b0110011, 3'b000, 7'h00, 12'd0, preg_t'(20 + i), 6'd3, preg_t'(21 + i));
	end
endtask

task automatic build_unsupported_test();
	push_instr(7'b0010011, 3'b000, 7'h00, 12'd123, 6'd0, 6'd0, 6'd30);
	push_instr(7'b0000011, 3'b010, 7'h00, 12'd4, 6'd1, 6'd0, 6'd30);  // Load
	push_instr(7'b0110011, 3'b000, 7'h00, 12'd0, 6'd30, 6'd30, 6'd31);
	push_instr(7'b0110011, 3'b001, 7'h00, 12'd0, 6'd31, 6'd1, 6'd32); // Shift left
	push_instr(7'b0110011, 3'b100, 7'h00, 12'd0, 6'd32, 6'd1, 6'd33);
endtask

task automatic build_random_test(input int n);
	int    kind;
	preg_t ps1;
	preg_t ps2;
	for (int i = 0; i < n; i++) begin
		kind = {$random(seed)} % 7;
		ps1  = preg_t'({$random(seed)} % PREG_COUNT);
		ps2  = preg_t'({$random(seed)} % PREG_COUNT);
		case (kind)
			0: push_instr(7'b0110011, 3'b000, 7'h00, 12'd0, ps1, ps2, rot_pd);
			1: push_instr(7'b0110011, 3'b000, 7'h20, 12'd0, ps1, ps2, rot_pd);
			2: push_instr(7'b0110011, 3'b100, 7'h00, 12'd0, ps1, ps2, rot_pd);
			3: push_instr(7'b0110011, 3'b101, 7'h20, 12'd0, ps1, ps2, rot_pd);
			4: push_instr(7'b0010011, 3'b000, 7'h00, 12'($random(seed)), ps1, ps2, rot_pd);
			5: push_instr(7'b0010011, 3'b111, 7'h00, 12'($random(seed)), ps1, ps2, rot_pd);
			default: push_instr(7'b0110011, 3'b110, 7'h00, 12'd0, ps1, ps2, rot_pd); // OR
		endcase
		rot_pd = (rot_pd == 6'd63) ? 6'd1 : rot_pd + 6'd1; // Reuse distance beyond 16 tags
	end
endtask

// File: tb/issue_core_tb.sv
`timescale 1ns/1ps

module issue_core_tb import issue_pkg::*; ();

	logic      clock;
	logic      rst_i;
	dispatch_t slot [DISPATCH_WIDTH];
	logic      dispatch_ready_o;
	result_t   res [ALU_COUNT];

	dispatch_t       stim_q[$];             // Program order, head is oldest
	logic [XLEN-1:0] model_reg [PREG_COUNT];
	logic [XLEN-1:0] exp_val [16][2];      // Two deep per tag for the reuse test
	preg_t           exp_pd  [16][2];
	int              exp_head [16];
	int              exp_cnt  [16];
	logic            ready_seen;
	logic            bp_seen;
	logic            allow_reuse;
	tag_t            next_tag;
	preg_t           rot_pd;
	int              seed;
	int              errors;
	int              checked;
	int              tests;
	int              cycles;
	int              cycle_limit;

	issue_core i_dut (
		.clock            (clock),
		.rst_i            (rst_i),
		.slot_i           (slot),
		.dispatch_ready_o (dispatch_ready_o),
		.result_o         (res)
	);

	`include "issue_core_tests.svh"

	always #50 clock = ~clock;

	// Reference model, RISC-V semantics with sign-extended I-type immediate
	function automatic void ref_exec(input dispatch_t d, output logic ok,
			output logic [XLEN-1:0] val);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm;
		a   = model_reg[d.ps1];
		b   = model_reg[d.ps2];
		imm = {{20{d.instr[31]}}, d.instr[31:20]};
		ok  = 1'b1;
		val = '0;
		if (d.opcode == 7'b0010011 && d.func3 == 3'b000) val = a + imm;
		else if (d.opcode == 7'b0010011 && d.func3 == 3'b111) val = a & imm;
		else if (d.opcode == 7'b0110011 && d.func3 == 3'b000 && d.func7 == 7'h00) val = a + b;
		else if (d.opcode == 7'b0110011 && d.func3 == 3'b000 && d.func7 == 7'h20) val = a - b;
		else if (d.opcode == 7'b0110011 && d.func3 == 3'b100 && d.func7 == 7'h00) val = a ^ b;
		else if (d.opcode == 7'b0110011 && d.func3 == 3'b101 && d.func7 == 7'h20)
			val = $signed(a) >>> b[4:0];
		else ok = 1'b0;
	endfunction

	task automatic check_value(input string name, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual);
		if (expected !== actual) begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// Executes an accepted instruction on the model and records what its tag must return
	task automatic accept_instr(input dispatch_t d);
		logic            ok;
		logic [XLEN-1:0] val;
		int              idx;
		ref_exec(d, ok, val);
		if (ok) begin
			if (d.pd != '0) model_reg[d.pd] = val;
			idx = (exp_head[d.tag] + exp_cnt[d.tag]) % 2;
			exp_val[d.tag][idx] = val;
			exp_pd[d.tag][idx]  = d.pd;
			exp_cnt[d.tag]++;
		end
	endtask

	function automatic logic tag_free(input tag_t t);
		return allow_reuse ? (exp_cnt[t] < 2) : (exp_cnt[t] == 0);
	endfunction

	task automatic present_slots();
		slot[0] = '0;
		slot[1] = '0;
		if (stim_q.size() > 0 && tag_free(stim_q[0].tag)) slot[0] = stim_q[0];
		if (stim_q.size() > 1 && slot[0].valid && tag_free(stim_q[1].tag) &&
				stim_q[1].tag != stim_q[0].tag) slot[1] = stim_q[1];
	endtask

	task automatic check_result(input result_t r);
		int h;
		if (exp_cnt[r.tag] == 0) begin
			$display("Error at %0t ns: result for tag %0d with no instruction outstanding",
				$time, r.tag);
			errors++;
		end else begin
			h = exp_head[r.tag];
			check_value($sformatf("result_o.value tag %0d", r.tag), exp_val[r.tag][h], r.value);
			check_value($sformatf("result_o.pd tag %0d", r.tag), exp_pd[r.tag][h], r.pd);
			exp_head[r.tag] = (h + 1) % 2;
			exp_cnt[r.tag]--;
			checked++;
		end
	endtask

	function automatic int outstanding();
		int n;
		n = 0;
		for (int t = 0; t < 16; t++) n += exp_cnt[t];
		return n;
	endfunction

	// Ready is stable at the falling edge and holds until the next rising edge
	always @(negedge clock) begin
		ready_seen = dispatch_ready_o;
		if (!rst_i && !dispatch_ready_o && slot[0].valid) bp_seen = 1'b1;
	end

	// Driver
	always @(posedge clock) begin
		if (!rst_i && ready_seen) begin
			for (int k = 0; k < DISPATCH_WIDTH; k++) begin
				if (slot[k].valid) begin
					accept_instr(stim_q.pop_front());
				end
			end
		end
		#1;
		present_slots();
	end

	// Comparison process
	always @(posedge clock) begin
		if (!rst_i) begin
			for (int a = 0; a < ALU_COUNT; a++) begin
				if (res[a].valid) check_result(res[a]);
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: %0d cycles passed with %0d results outstanding", cycles,
				outstanding());
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic run_test(input string name);
		int err0;
		int n;
		err0 = errors;
		n    = stim_q.size();
		cycle_limit += 8 * n;
		while (stim_q.size() != 0 || outstanding() != 0) @(posedge clock);
		tests++;
		$display("Test %s: %0d instructions, %0d errors", name, n, errors - err0);
	endtask

	initial begin
		clock       = 1'b0;
		rst_i       = 1'b1;
		slot[0]     = '0;
		slot[1]     = '0;
		ready_seen  = 1'b0;
		bp_seen     = 1'b0;
		allow_reuse = 1'b0;
		next_tag    = '0;
		rot_pd      = 6'd1;
		seed        = 7;
		errors      = 0;
		checked     = 0;
		tests       = 0;
		cycles      = 0;
		cycle_limit = 200 + 16;
		for (int i = 0; i < PREG_COUNT; i++) model_reg[i] = '0;
		for (int t = 0; t < 16; t++) begin
			exp_head[t] = 0;
			exp_cnt[t]  = 0;
		end
		repeat (16) @(posedge clock);
		#1 rst_i = 1'b0;
		@(negedge clock);
		check_value("result_o[0].valid", 1'b0, res[0].valid);
		check_value("result_o[1].valid", 1'b0, res[1].valid);
		check_value("dispatch_ready_o", 1'b1, dispatch_ready_o);
		tests++;
		$display("Test reset: %0d errors", errors);

		build_imm_test();
		run_test("immediate");
		build_chain_test();
		run_test("dependent chain");
		allow_reuse = 1'b1;
		bp_seen     = 1'b0;
		build_backpressure_test();
		run_test("back-pressure");
		check_value("dispatch_ready_o low seen", 1'b1, bp_seen);
		allow_reuse = 1'b0;
		build_unsupported_test();
		run_test("unsupported opcode");
		build_random_test(200);
		run_test("random mix");

		$display("Tests: %0d, results checked: %0d, errors: %0d", tests, checked, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+tb
src/issue_pkg.sv
src/dispatch_decode.sv
src/preg_file.sv
src/reservation_station.sv
src/alu_unit.sv
src/issue_core.sv
tb/issue_core_tb.sv
